//--- sim.f
mfp_pkg.sv
mfp_fifo.sv
mfp_timer.sv
mfp_irq.sv
mfp.sv
mfp_chk.sv
mfp_scoreboard.sv
tb_mfp.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module tb_mfp -o tb_mfp \
	&& ./obj_dir/tb_mfp | tee /dev/stderr | grep -qx ">>> PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_mfp.sv
/* mfp testbench */
module tb_mfp;
	import mfp_pkg::*;

	localparam int DEPTH = 8;

	logic       clk, reset;
	logic       sel_i, rw_i, iack_i, dtack_o, irq_o;
	logic [4:0] addr_i;
	logic [7:0] din_i, dout_o;
	logic [7:0] tx_data_o, rx_data_i, gpio_i, gpio_o;
	logic       tx_avail_o, tx_strobe_i, rx_strobe_i, rx_full_o;
	int         sb_errors, sb_checks;
	int         tb_errors;
	logic [31:0] rng;

	mfp #(.FIFO_DEPTH(DEPTH)) i_dut (.*);

	mfp_scoreboard #(.DEPTH(DEPTH)) i_sb (.*, .errors_o(sb_errors), .checks_o(sb_checks));

	bind mfp mfp_chk i_chk (.clk(clk), .reset(reset), .sel_i(sel_i), .iack_i(iack_i),
		.dtack_o(dtack_o), .irq_o(irq_o), .tx_avail_o(tx_avail_o), .tx_strobe_i(tx_strobe_i));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	task automatic roll(output logic [31:0] r);
		rng = xorshift(rng);
		r   = rng;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// one select cycle, returns dout_o at dtack
	task automatic bus_access(input logic [4:0] a, input logic rd, input logic [7:0] d,
		output logic [7:0] q);
		int n;
		next_cycle();
		sel_i  = 1'b1;
		rw_i   = rd;
		addr_i = a;
		din_i  = d;
		n = 0;
		next_cycle();
		while (!dtack_o && n < 20) begin
			next_cycle();
			n++;
		end
		if (!dtack_o) begin
			$display("timeout: no dtack on bus access to register %h", a);
			tb_errors++;
		end
		q      = dout_o;
		next_cycle(); // cpu ends the cycle an edge after dtack
		sel_i  = 1'b0;
		rw_i   = 1'b1;
	endtask

	task automatic reg_write(input logic [4:0] a, input logic [7:0] d);
		logic [7:0] q;
		bus_access(a, 1'b0, d, q);
	endtask

	task automatic reg_read(input logic [4:0] a, output logic [7:0] q);
		bus_access(a, 1'b1, 8'd0, q);
	endtask

	task automatic ack_cycle(output logic [7:0] v);
		int n;
		next_cycle();
		iack_i = 1'b1;
		n = 0;
		next_cycle();
		while (!dtack_o && n < 20) begin
			next_cycle();
			n++;
		end
		if (!dtack_o) begin
			$display("timeout: no dtack during interrupt acknowledge");
			tb_errors++;
		end
		v      = dout_o;
		next_cycle(); // vector stays on the bus for one edge
		iack_i = 1'b0;
		next_cycle(); // iack_q must clear before next rise
	endtask

	task automatic tx_pop();
		next_cycle();
		tx_strobe_i = 1'b1;
		next_cycle();
		tx_strobe_i = 1'b0;
	endtask

	task automatic rx_push(input logic [7:0] d);
		next_cycle();
		rx_strobe_i = 1'b1;
		rx_data_i   = d;
		next_cycle();
		rx_strobe_i = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  q, v, prev_cnt;
		logic [4:0]  ctrl_a, data_a;
		logic [15:0] bit16;
		int          prev, n, start, limit, ups;
		{sel_i, iack_i, tx_strobe_i, rx_strobe_i} = '0;
		rw_i = 1'b1;
		{addr_i, din_i, rx_data_i, gpio_i} = '0;
		tb_errors = 0;
		rng   = 32'h24b6_53e9;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		// register readback, ier limited to gpio sources
		for (int k = 0; k < 12; k++) begin
			roll(r);
			gpio_i = r[31:24];
			reg_write(AER, r[7:0]);
			reg_write(DDR, r[15:8]);
			reg_write(GPIP, r[23:16]);
			reg_write(IERA, r[7:0] & 8'hc0);
			reg_write(IERB, r[15:8] & 8'hcf);
			reg_write(IMRA, r[23:16]);
			reg_write(IMRB, r[31:24]);
			reg_write(VR, r[15:8] & 8'hf7);
			reg_write(TACR, {5'd0, r[2:0]});
			reg_write(TBCR, {5'd0, r[5:3]});
			reg_write(TCDCR, {1'b0, r[14:8]});
			for (int a = 0; a <= 5'h0e; a++)
				reg_read(a[4:0], q);
		end
		reg_write(TACR, 8'd0);
		reg_write(TBCR, 8'd0);
		reg_write(TCDCR, 8'd0);
		reg_write(IERA, 8'd0);
		reg_write(IERB, 8'd0);

		// transmit path with random pops
		for (int k = 0; k < 60; k++) begin
			roll(r);
			case (r[1:0])
				2'd0, 2'd1: reg_write(UDR, r[15:8]);
				2'd2: tx_pop();
				default: reg_read(TSR, q);
			endcase
		end
		n = 0;
		while (tx_avail_o && n < 40) begin
			tx_pop();
			n++;
		end
		if (tx_avail_o) begin
			$display("timeout: transmit fifo did not drain");
			tb_errors++;
		end

		// receive path
		for (int k = 0; k < 60; k++) begin
			roll(r);
			case (r[1:0])
				2'd0, 2'd1: rx_push(r[15:8]);
				2'd2: reg_read(UDR, q);
				default: reg_read(RSR, q);
			endcase
		end
		n = 0;
		reg_read(RSR, q);
		while (q[7] && n < 40) begin
			reg_read(UDR, q);
			reg_read(RSR, q);
			n++;
		end
		if (q[7]) begin
			$display("timeout: receive fifo did not drain");
			tb_errors++;
		end

		// gpio interrupts, software end of interrupt
		roll(r);
		reg_write(VR, (r[7:0] & 8'hf0) | 8'h08);
		reg_write(AER, r[15:8]);
		reg_write(IMRA, 8'hc0);
		reg_write(IMRB, 8'hcf);
		reg_write(IERA, r[23:16] & 8'hc0);
		reg_write(IERB, r[31:24] & 8'hcf);
		for (int k = 0; k < 40; k++) begin
			roll(r);
			gpio_i[r[2:0]] = ~gpio_i[r[2:0]];
			next_cycle();
			reg_read(IPRA, q);
			reg_read(IPRB, q);
			if (r[8])
				reg_write(IMRB, r[23:16] & 8'hcf); // masked bits still pend
			if (irq_o) begin
				ack_cycle(v);
				reg_read(ISRA, q);
				reg_read(ISRB, q);
				reg_write(ISRA, 8'd0);
				reg_write(ISRB, 8'd0);
			end
		end

		// priority, acks run from highest index down
		reg_write(IERA, 8'd0);
		reg_write(IERB, 8'd0);
		gpio_i = 8'd0;
		reg_write(AER, 8'hff);
		reg_write(IMRA, 8'hc0);
		reg_write(IMRB, 8'hcf);
		reg_write(VR, 8'h48);
		for (int rep = 0; rep < 6; rep++) begin
			reg_write(IERA, 8'hc0);
			reg_write(IERB, 8'hcf);
			roll(r);
			gpio_i = r[7:0] | 8'h01; // rising edges on several pins
			next_cycle();
			next_cycle();
			prev = 16;
			n = 0;
			while (irq_o && n < 10) begin
				ack_cycle(v);
				if (int'(v[3:0]) >= prev) begin
					$display("Fail t=%0t vector index %0d not below %0d", $time, v[3:0], prev);
					tb_errors++;
				end
				prev = int'(v[3:0]);
				reg_write(ISRA, 8'd0);
				reg_write(ISRB, 8'd0);
				n++;
			end
			if (irq_o) begin
				$display("timeout: irq_o stayed high through ten acknowledges");
				tb_errors++;
			end
			gpio_i = 8'd0;
			reg_write(IERA, 8'd0);
			reg_write(IERB, 8'd0);
		end

		// timers, one after another with masks off
		reg_write(IMRA, 8'd0);
		reg_write(IMRB, 8'd0);
		for (int k = 0; k < 4; k++) begin
			roll(r);
			ctrl_a = (k == 0) ? TACR : (k == 1) ? TBCR : TCDCR;
			data_a = TADR + 5'(k);
			bit16  = 16'd1 << ((k == 0) ? SRC_TA : (k == 1) ? SRC_TB :
				(k == 2) ? SRC_TC : SRC_TD);
			v      = 8'd1 + 8'(r[2:0] % 3); // mode 1..3
			reg_write(IERA, bit16[15:8]);
			reg_write(IERB, bit16[7:0]);
			reg_write(data_a, 8'd1 + 8'(r[15:8] % 20));
			limit = int'(PRESCALE[v[2:0]]) * (1 + int'(r[15:8] % 20)) + 12;
			reg_write(ctrl_a, (k == 2) ? {1'b0, v[2:0], 4'd0} : v);
			start    = int'($time);
			prev_cnt = 8'hff;
			ups      = 0;
			q        = 8'd0;
			while (q == 8'd0 && (int'($time) - start) / 8 <= limit) begin
				reg_read(bit16[15:8] != 0 ? IPRA : IPRB, q);
				q = q & ((bit16[15:8] != 0) ? bit16[15:8] : bit16[7:0]);
				reg_read(data_a, v);
				if (v > prev_cnt)
					ups++; // one reload may land between polls
				if (ups > 1) begin
					$display("Fail t=%0t timer %0d count exp <= %h got %h",
						$time, k, prev_cnt, v);
					tb_errors++;
					ups = 0;
				end
				prev_cnt = v;
			end
			if (q == 8'd0) begin
				$display("timeout: timer %0d pending bit missing after %0d cycles", k, limit);
				tb_errors++;
			end
			reg_write(ctrl_a, 8'd0);
			reg_write(IERA, 8'd0);
			reg_write(IERB, 8'd0);
		end

		repeat (4) next_cycle();
		$display("checks %0d, scoreboard errors %0d, testbench errors %0d",
			sb_checks, sb_errors, tb_errors);
		if (sb_errors == 0 && tb_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- mfp_scoreboard.sv
/* mfp reference model */
module mfp_scoreboard #(
	parameter int DEPTH = 8
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       sel_i,
	input  logic       rw_i,
	input  logic [4:0] addr_i,
	input  logic [7:0] din_i,
	input  logic [7:0] dout_o,
	input  logic       dtack_o,
	input  logic       iack_i,
	input  logic       irq_o,
	input  logic [7:0] tx_data_o,
	input  logic       tx_avail_o,
	input  logic       tx_strobe_i,
	input  logic       rx_strobe_i,
	input  logic [7:0] rx_data_i,
	input  logic       rx_full_o,
	input  logic [7:0] gpio_i,
	input  logic [7:0] gpio_o,
	output int         errors_o,
	output int         checks_o
);
	import mfp_pkg::*;

	localparam logic [15:0] GPIO_MASK = 16'hc0cf; // only gpio pending is modeled

	logic [7:0]  gpip, aer, ddr, vr, vec;
	logic [7:0]  ctrl_a, ctrl_b, ctrl_cd;
	logic [15:0] ier, imr, ipr, isr;
	logic [7:0]  gsrc_q; // gpio source history
	logic        sel_q, iack_q, udr_rd_q;
	logic [7:0]  txq [$];
	logic [7:0]  rxq [$];

	// pin number to source position
	function automatic logic [15:0] spread(input logic [7:0] g);
		return {g[7:6], 6'd0, g[5:4], 2'd0, g[3:0]};
	endfunction

	function automatic int top_index(input logic [15:0] v);
		int idx;
		idx = -1; // nothing set
		for (int k = 0; k < 16; k++)
			if (v[k])
				idx = k;
		return idx;
	endfunction

	task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks_o++;
		if (exp !== got) begin
			errors_o++;
			$display("Fail t=%0t %s exp %h got %h", $time, name, exp, got);
		end
	endtask

	initial begin
		errors_o = 0;
		checks_o = 0;
	end

	always @(posedge clk) begin
		logic [15:0] nw, pend, keep_p, keep_i, set_i;
		logic [7:0]  gs, exp, msk;
		logic        valid, push_tx, push_rx;
		int          idx;
		if (reset) begin
			{gpip, aer, ddr, vr, vec} = '0;
			{ctrl_a, ctrl_b, ctrl_cd} = '0;
			{ier, imr, ipr, isr} = '0;
			{gsrc_q, sel_q, iack_q, udr_rd_q} = '0;
			txq.delete();
			rxq.delete();
		end else begin
			// outputs against model state before this edge
			compare("gpio_o", gpip & ddr, gpio_o);
			compare("dtack_o", {7'd0, (sel_i && sel_q) || (iack_i && iack_q)},
				{7'd0, dtack_o}); // strobe held past one registered cycle
			compare("tx_avail_o", {7'd0, txq.size() != 0}, {7'd0, tx_avail_o});
			compare("rx_full_o", {7'd0, rxq.size() == DEPTH}, {7'd0, rx_full_o});
			pend = ipr & imr;
			if ((ier & ~GPIO_MASK) == 16'd0) // unmodeled sources off
				compare("irq_o", {7'd0, (pend != 0) && ((isr == 0) ||
					(top_index(pend) > top_index(isr)))}, {7'd0, irq_o});
			if (sel_i && rw_i && sel_q) begin
				valid = 1'b1;
				msk   = 8'hff;
				exp   = 8'd0;
				case (addr_i)
					GPIP:  exp = (gpio_i & ~ddr) | (gpip & ddr);
					AER:   exp = aer;
					DDR:   exp = ddr;
					IERA:  exp = ier[15:8];
					IERB:  exp = ier[7:0];
					IPRA:  begin exp = ipr[15:8]; msk = GPIO_MASK[15:8]; end
					IPRB:  begin exp = ipr[7:0]; msk = GPIO_MASK[7:0]; end
					ISRA:  exp = isr[15:8];
					ISRB:  exp = isr[7:0];
					IMRA:  exp = imr[15:8];
					IMRB:  exp = imr[7:0];
					VR:    exp = vr;
					TACR:  exp = ctrl_a;
					TBCR:  exp = ctrl_b;
					TCDCR: exp = ctrl_cd;
					RSR:   exp = {rxq.size() != 0, 7'd0};
					TSR:   exp = {txq.size() < DEPTH, 7'd0};
					UDR:   if (rxq.size() != 0) exp = rxq[0]; else valid = 1'b0;
					default: valid = 1'b0; // live timer counts
				endcase
				if (valid)
					compare($sformatf("dout_o[%h]", addr_i), exp & msk, dout_o & msk);
			end
			if (iack_i && iack_q && !sel_i)
				compare("dout_o vector", vec, dout_o);

			// gpio edges, old aer and ier apply
			gs     = gpio_i ^ ~aer;
			nw     = spread(gs & ~gsrc_q) & ier;
			gsrc_q = gs;
			keep_p = '1;
			keep_i = '1;
			set_i  = '0;
			if (iack_i && !iack_q) begin
				idx = top_index(pend);
				vec = (vr & 8'hf0) + ((idx < 0) ? 8'd0 : 8'(idx));
				if (idx >= 0) begin
					keep_p[idx] = 1'b0;
					if (vr[3])
						set_i[idx] = 1'b1;
				end
			end
			push_tx = (txq.size() < DEPTH); // full check before a same-cycle pop
			push_rx = (rxq.size() < DEPTH);
			if (tx_strobe_i && txq.size() != 0) begin
				compare("tx_data_o", txq[0], tx_data_o);
				void'(txq.pop_front());
			end
			if (udr_rd_q && !sel_i && rxq.size() != 0)
				void'(rxq.pop_front());
			if (rx_strobe_i && push_rx)
				rxq.push_back(rx_data_i);
			if (sel_i && !sel_q && !rw_i) begin
				case (addr_i)
					GPIP:  gpip = din_i;
					AER:   aer = din_i;
					DDR:   ddr = din_i;
					IERA:  begin ier[15:8] = din_i; keep_p[15:8] = din_i; end
					IERB:  begin ier[7:0] = din_i; keep_p[7:0] = din_i; end
					IPRA:  keep_p[15:8] = din_i;
					IPRB:  keep_p[7:0] = din_i;
					ISRA:  keep_i[15:8] = din_i;
					ISRB:  keep_i[7:0] = din_i;
					IMRA:  imr[15:8] = din_i;
					IMRB:  imr[7:0] = din_i;
					VR:    vr = din_i;
					TACR:  ctrl_a = din_i & 8'h07;
					TBCR:  ctrl_b = din_i & 8'h07;
					TCDCR: ctrl_cd = din_i & 8'h77;
					UDR:   if (push_tx) txq.push_back(din_i); // else dropped
					default: ;
				endcase
			end
			ipr      = (ipr & keep_p) | nw;
			isr      = (isr & keep_i) | set_i;
			udr_rd_q = sel_i && rw_i && (addr_i == UDR);
			sel_q    = sel_i;
			iack_q   = iack_i;
		end
	end

endmodule

//--- mfp_chk.sv
/* bus and flag assertions */
module mfp_chk (
	input logic clk,
	input logic reset,
	input logic sel_i,
	input logic iack_i,
	input logic dtack_o,
	input logic irq_o,
	input logic tx_avail_o,
	input logic tx_strobe_i
);

	// dtack drops once both strobes are gone
	dtack_release: assert property (@(posedge clk) disable iff (reset)
		(!sel_i && !iack_i) |=> !dtack_o)
		else $error("dtack_o still high after sel_i and iack_i went low");

	// no interrupt while held in reset
	irq_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> !irq_o)
		else $error("irq_o high during reset");

	// only a pop empties the transmit fifo
	tx_avail_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(tx_avail_o) |-> $past(tx_strobe_i))
		else $error("tx_avail_o fell without a tx_strobe_i");

endmodule

//--- mfp.sv
/* multi-function peripheral top */
module mfp #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                       clk,
	input  logic                       reset,
	// cpu bus
	input  logic                       sel_i,
	input  logic                       rw_i,   // high reads
	input  logic [mfp_pkg::ADDR_W-1:0] addr_i,
	input  logic [7:0]                 din_i,
	output logic [7:0]                 dout_o,
	output logic                       dtack_o,
	input  logic                       iack_i,
	output logic                       irq_o,
	// io controller
	output logic [7:0]                 tx_data_o,
	output logic                       tx_avail_o,
	input  logic                       tx_strobe_i,
	input  logic                       rx_strobe_i,
	input  logic [7:0]                 rx_data_i,
	output logic                       rx_full_o,
	// gpio
	input  logic [7:0]                 gpio_i,
	output logic [7:0]                 gpio_o
);
	import mfp_pkg::*;

	logic             sel_q;
	logic             iack_q;
	logic             udr_rd_q;  // udr read in progress
	logic             wr_pulse;
	logic             rx_pop;
	logic [7:0]       gpip;
	logic [7:0]       aer;
	logic [7:0]       ddr;
	logic [7:0]       gpio_edge;
	logic [7:0]       gpip_rd;
	logic             tx_empty;
	logic             tx_full;
	logic             rx_empty;
	logic [7:0]       rx_head;
	logic [2:0]       ta_ctrl, tb_ctrl, tc_ctrl, td_ctrl;
	logic [7:0]       ta_cnt, tb_cnt, tc_cnt, td_cnt;
	logic             ta_done, tb_done, tc_done, td_done;
	logic [IRQ_W-1:0] src;
	logic [IRQ_W-1:0] ier, imr, ipr, isr;
	logic [7:0]       vr;
	logic [7:0]       vec;

	// one write per select rise
	assign wr_pulse = sel_i && !sel_q && !rw_i;
	assign dtack_o  = (sel_q && sel_i) || (iack_q && iack_i);
	assign rx_pop   = udr_rd_q && !sel_i; // pop as the udr read ends

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_q    <= 1'b0;
			iack_q   <= 1'b0;
			udr_rd_q <= 1'b0;
		end else begin
			sel_q    <= sel_i;
			iack_q   <= iack_i;
			udr_rd_q <= sel_i && rw_i && (addr_i == UDR);
		end
	end

	// gpio registers
	always_ff @(posedge clk) begin
		if (reset) begin
			gpip <= 8'd0;
			aer  <= 8'd0;
			ddr  <= 8'd0;
		end else if (wr_pulse) begin
			case (addr_i)
				GPIP: gpip <= din_i;
				AER:  aer  <= din_i;
				DDR:  ddr  <= din_i;
				default: ;
			endcase
		end
	end

	assign gpio_o    = gpip & ddr;                     // ddr 1 drives pin
	assign gpip_rd   = (gpio_i & ~ddr) | (gpip & ddr);
	assign gpio_edge = gpio_i ^ ~aer;                  // aer 1 -> rising edge

	mfp_fifo #(.DEPTH(FIFO_DEPTH)) i_tx_fifo (
		.clk     (clk),
		.reset   (reset),
		.push_i  (wr_pulse && (addr_i == UDR)),
		.data_i  (din_i),
		.pop_i   (tx_strobe_i),
		.data_o  (tx_data_o),
		.empty_o (tx_empty),
		.full_o  (tx_full),
		.count_o ()
	);

	mfp_fifo #(.DEPTH(FIFO_DEPTH)) i_rx_fifo (
		.clk     (clk),
		.reset   (reset),
		.push_i  (rx_strobe_i),
		.data_i  (rx_data_i),
		.pop_i   (rx_pop),
		.data_o  (rx_head),
		.empty_o (rx_empty),
		.full_o  (rx_full_o),
		.count_o ()
	);

	assign tx_avail_o = !tx_empty;

	mfp_timer i_timer_a (
		.clk (clk), .reset (reset),
		.ctrl_we_i (wr_pulse && (addr_i == TACR)), .ctrl_i (din_i[2:0]),
		.data_we_i (wr_pulse && (addr_i == TADR)), .data_i (din_i),
		.ctrl_o (ta_ctrl), .count_o (ta_cnt), .done_o (ta_done)
	);

	mfp_timer i_timer_b (
		.clk (clk), .reset (reset),
		.ctrl_we_i (wr_pulse && (addr_i == TBCR)), .ctrl_i (din_i[2:0]),
		.data_we_i (wr_pulse && (addr_i == TBDR)), .data_i (din_i),
		.ctrl_o (tb_ctrl), .count_o (tb_cnt), .done_o (tb_done)
	);

	mfp_timer i_timer_c (
		.clk (clk), .reset (reset),
		.ctrl_we_i (wr_pulse && (addr_i == TCDCR)), .ctrl_i (din_i[6:4]),
		.data_we_i (wr_pulse && (addr_i == TCDR)), .data_i (din_i),
		.ctrl_o (tc_ctrl), .count_o (tc_cnt), .done_o (tc_done)
	);

	mfp_timer i_timer_d (
		.clk (clk), .reset (reset),
		.ctrl_we_i (wr_pulse && (addr_i == TCDCR)), .ctrl_i (din_i[2:0]),
		.data_we_i (wr_pulse && (addr_i == TDDR)), .data_i (din_i),
		.ctrl_o (td_ctrl), .count_o (td_cnt), .done_o (td_done)
	);

	// source vector, error bits stay zero
	always_comb begin
		src            = '0;
		src[SRC_GPIO0] = gpio_edge[0];
		src[SRC_GPIO1] = gpio_edge[1];
		src[SRC_GPIO2] = gpio_edge[2];
		src[SRC_GPIO3] = gpio_edge[3];
		src[SRC_TD]    = td_done;
		src[SRC_TC]    = tc_done;
		src[SRC_GPIO4] = gpio_edge[4];
		src[SRC_GPIO5] = gpio_edge[5];
		src[SRC_TB]    = tb_done;
		src[SRC_TX]    = !tx_full && !tx_strobe_i; // drops for a cycle on each pop
		src[SRC_RX]    = !rx_empty && !rx_pop;     // re-arms if more data left
		src[SRC_TA]    = ta_done;
		src[SRC_GPIO6] = gpio_edge[6];
		src[SRC_GPIO7] = gpio_edge[7];
	end

	mfp_irq i_irq (
		.clk    (clk),
		.reset  (reset),
		.src_i  (src),
		.wr_i   (wr_pulse),
		.addr_i (addr_i),
		.din_i  (din_i),
		.iack_i (iack_i),
		.ier_o  (ier),
		.imr_o  (imr),
		.ipr_o  (ipr),
		.isr_o  (isr),
		.vr_o   (vr),
		.vec_o  (vec),
		.irq_o  (irq_o)
	);

	// cpu read mux
	always_comb begin
		dout_o = 8'd0;
		if (sel_i && rw_i) begin
			case (addr_i)
				GPIP:  dout_o = gpip_rd;
				AER:   dout_o = aer;
				DDR:   dout_o = ddr;
				IERA:  dout_o = ier[15:8];
				IERB:  dout_o = ier[7:0];
				IPRA:  dout_o = ipr[15:8];
				IPRB:  dout_o = ipr[7:0];
				ISRA:  dout_o = isr[15:8];
				ISRB:  dout_o = isr[7:0];
				IMRA:  dout_o = imr[15:8];
				IMRB:  dout_o = imr[7:0];
				VR:    dout_o = vr;
				TACR:  dout_o = {5'd0, ta_ctrl};
				TBCR:  dout_o = {5'd0, tb_ctrl};
				TCDCR: dout_o = {1'b0, tc_ctrl, 1'b0, td_ctrl};
				TADR:  dout_o = ta_cnt;
				TBDR:  dout_o = tb_cnt;
				TCDR:  dout_o = tc_cnt;
				TDDR:  dout_o = td_cnt;
				RSR:   dout_o = {!rx_empty, 7'd0}; // receive data available
				TSR:   dout_o = {!tx_full, 7'd0};  // room in transmit fifo
				UDR:   dout_o = rx_head;
				default: ;
			endcase
		end else if (iack_i && !sel_i) begin
			dout_o = vec; // vector during acknowledge
		end
	end

endmodule

//--- mfp_irq.sv
/* interrupt controller */
module mfp_irq (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [mfp_pkg::IRQ_W-1:0] src_i,
	input  logic                      wr_i,
	input  logic [mfp_pkg::ADDR_W-1:0] addr_i,
	input  logic [7:0]                din_i,
	input  logic                      iack_i,
	output logic [mfp_pkg::IRQ_W-1:0] ier_o,
	output logic [mfp_pkg::IRQ_W-1:0] imr_o,
	output logic [mfp_pkg::IRQ_W-1:0] ipr_o,
	output logic [mfp_pkg::IRQ_W-1:0] isr_o,
	output logic [7:0]                vr_o,
	output logic [7:0]                vec_o,
	output logic                      irq_o
);
	import mfp_pkg::*;

	logic [IRQ_W-1:0] ier;
	logic [IRQ_W-1:0] imr;
	logic [IRQ_W-1:0] ipr;
	logic [IRQ_W-1:0] isr;
	logic [7:0]       vr;
	logic [7:0]       vec;       // held through the ack cycle
	logic [IRQ_W-1:0] src_q;     // source edge detect
	logic             iack_q;
	logic [IRQ_W-1:0] pend;      // pending and unmasked
	logic [IDX_W-1:0] pend_idx;
	logic [IDX_W-1:0] isr_idx;
	logic             ack;
	logic [IRQ_W-1:0] ipr_keep;  // zero bits clear pending
	logic [IRQ_W-1:0] isr_keep;
	logic [IRQ_W-1:0] isr_set;

	// index of highest set bit, 0 when empty
	function automatic logic [IDX_W-1:0] hbit(input logic [IRQ_W-1:0] v);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int k = 0; k < IRQ_W; k++)
			if (v[k])
				idx = k[IDX_W-1:0];
		return idx;
	endfunction

	assign pend     = ipr & imr;
	assign pend_idx = hbit(pend);
	assign isr_idx  = hbit(isr);
	assign ack      = iack_i && !iack_q && (pend != '0); // iack rise

	// only a higher source interrupts one in service
	assign irq_o = (pend != '0) && ((isr == '0) || (pend_idx > isr_idx));

	always_comb begin
		ipr_keep = '1;
		isr_keep = '1;
		isr_set  = '0;
		if (wr_i) begin
			case (addr_i)
				IERA: ipr_keep[15:8] = din_i; // disabled sources lose pending
				IERB: ipr_keep[7:0]  = din_i;
				IPRA: ipr_keep[15:8] = din_i;
				IPRB: ipr_keep[7:0]  = din_i;
				ISRA: isr_keep[15:8] = din_i;
				ISRB: isr_keep[7:0]  = din_i;
				default: ;
			endcase
		end
		if (ack) begin
			ipr_keep[pend_idx] = 1'b0; // winner leaves pending
			if (vr[3])
				isr_set[pend_idx] = 1'b1; // software end of interrupt mode
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ier    <= '0;
			imr    <= '0;
			ipr    <= '0;
			isr    <= '0;
			vr     <= 8'd0;
			vec    <= 8'd0;
			src_q  <= '0;
			iack_q <= 1'b0;
		end else begin
			src_q  <= src_i;
			iack_q <= iack_i;
			ipr    <= (ipr & ipr_keep) | (src_i & ~src_q & ier); // new edge wins
			isr    <= (isr & isr_keep) | isr_set;
			if (iack_i && !iack_q)
				vec <= {vr[7:4], pend_idx};
			if (wr_i) begin
				case (addr_i)
					IERA: ier[15:8] <= din_i;
					IERB: ier[7:0]  <= din_i;
					IMRA: imr[15:8] <= din_i;
					IMRB: imr[7:0]  <= din_i;
					VR:   vr        <= din_i;
					default: ;
				endcase
			end
		end
	end

	assign ier_o = ier;
	assign imr_o = imr;
	assign ipr_o = ipr;
	assign isr_o = isr;
	assign vr_o  = vr;
	assign vec_o = vec;

endmodule

//--- mfp_timer.sv
/* delay mode timer */
module mfp_timer (
	input  logic       clk,
	input  logic       reset,
	input  logic       ctrl_we_i,
	input  logic [2:0] ctrl_i,
	input  logic       data_we_i,
	input  logic [7:0] data_i,
	output logic [2:0] ctrl_o,
	output logic [7:0] count_o,
	output logic       done_o
);
	import mfp_pkg::*;

	logic [2:0]       mode;   // prescaler select, 0 stops
	logic [7:0]       reload; // data register as written
	logic [PSC_W-1:0] psc;    // prescaler count
	logic [7:0]       cnt;    // main down counter
	logic             running;
	logic             tick;

	assign running = (mode != 3'd0);

	// one tick every PRESCALE[mode] clocks
	assign tick = running && (psc == PRESCALE[mode] - PSC_W'(1));

	assign ctrl_o  = mode;
	assign count_o = cnt; // data reads see live count

	// control register and prescaler
	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= 3'd0;
			psc  <= '0;
		end else begin
			if (ctrl_we_i)
				mode <= ctrl_i;
			if (ctrl_we_i || tick || !running)
				psc <= '0; // restart on write, wrap on tick
			else
				psc <= psc + 1'b1;
		end
	end

	// reload register and main counter
	always_ff @(posedge clk) begin
		if (reset) begin
			reload <= 8'd0;
			cnt    <= 8'd0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (data_we_i) begin
				reload <= data_i;
				if (!running)
					cnt <= data_i; // stopped timer loads at once
			end
			if (tick) begin
				if (cnt == 8'd1) begin
					cnt    <= reload; // terminal count
					done_o <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1; // 0 wraps to 255, so 0 acts as 256
				end
			end
		end
	end

endmodule

//--- mfp_fifo.sv
/* byte fifo, first word fall through */
module mfp_fifo #(
	parameter int DEPTH = 8 // power of two
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   push_i,
	input  logic [7:0]             data_i,
	input  logic                   pop_i,
	output logic [7:0]             data_o,
	output logic                   empty_o,
	output logic                   full_o,
	output logic [$clog2(DEPTH):0] count_o
);
	localparam int PTR_W = $clog2(DEPTH);

	logic [7:0]       mem [DEPTH]; // storage, no reset
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// strobes into a full or out of an empty fifo are dropped
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign empty_o = (count == '0);
	assign full_o  = (count == DEPTH[PTR_W:0]);
	assign count_o = count;
	assign data_o  = mem[rd_ptr]; // head visible without pop

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^n
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

//--- mfp_pkg.sv
/* mfp shared constants */
package mfp_pkg;

	localparam int ADDR_W = 5; // register bus address
	localparam int IRQ_W  = 16; // interrupt sources
	localparam int IDX_W  = $clog2(IRQ_W);
	localparam int PSC_W  = 8; // prescaler counter, max ratio 200

	// register map, "A" halves hold bits 15..8
	localparam logic [ADDR_W-1:0] GPIP  = 5'h00;
	localparam logic [ADDR_W-1:0] AER   = 5'h01;
	localparam logic [ADDR_W-1:0] DDR   = 5'h02;
	localparam logic [ADDR_W-1:0] IERA  = 5'h03;
	localparam logic [ADDR_W-1:0] IERB  = 5'h04;
	localparam logic [ADDR_W-1:0] IPRA  = 5'h05;
	localparam logic [ADDR_W-1:0] IPRB  = 5'h06;
	localparam logic [ADDR_W-1:0] ISRA  = 5'h07;
	localparam logic [ADDR_W-1:0] ISRB  = 5'h08;
	localparam logic [ADDR_W-1:0] IMRA  = 5'h09;
	localparam logic [ADDR_W-1:0] IMRB  = 5'h0a;
	localparam logic [ADDR_W-1:0] VR    = 5'h0b;
	localparam logic [ADDR_W-1:0] TACR  = 5'h0c;
	localparam logic [ADDR_W-1:0] TBCR  = 5'h0d;
	localparam logic [ADDR_W-1:0] TCDCR = 5'h0e; // c in 6..4, d in 2..0
	localparam logic [ADDR_W-1:0] TADR  = 5'h0f;
	localparam logic [ADDR_W-1:0] TBDR  = 5'h10;
	localparam logic [ADDR_W-1:0] TCDR  = 5'h11;
	localparam logic [ADDR_W-1:0] TDDR  = 5'h12;
	localparam logic [ADDR_W-1:0] RSR   = 5'h15; // 0x13/0x14 not implemented
	localparam logic [ADDR_W-1:0] TSR   = 5'h16;
	localparam logic [ADDR_W-1:0] UDR   = 5'h17;

	// interrupt source bit positions
	localparam int SRC_GPIO0 = 0;
	localparam int SRC_GPIO1 = 1;
	localparam int SRC_GPIO2 = 2;
	localparam int SRC_GPIO3 = 3;
	localparam int SRC_TD    = 4;
	localparam int SRC_TC    = 5;
	localparam int SRC_GPIO4 = 6;
	localparam int SRC_GPIO5 = 7;
	localparam int SRC_TB    = 8;
	localparam int SRC_TX    = 10; // 9 and 11 are error sources, tied low
	localparam int SRC_RX    = 12;
	localparam int SRC_TA    = 13;
	localparam int SRC_GPIO6 = 14;
	localparam int SRC_GPIO7 = 15;

	// divide ratio per 3-bit timer mode, 0 means stopped
	localparam logic [PSC_W-1:0] PRESCALE [8] = '{8'd0, 8'd4, 8'd10, 8'd16,
		8'd50, 8'd64, 8'd100, 8'd200};

endpackage
